// File: rtl/obj_macros.svh
//######################################
// Object engine sizes
// Table, line buffer and ROM dimensions
//######################################
`ifndef OBJ_MACROS_SVH
`define OBJ_MACROS_SVH

// Entries in one table bank
`define OBJ_ENTRIES 128

// 16-bit words per entry
`define OBJ_WORDS 4

// Pixels in one line buffer half
`define OBJ_LINE_W 512

// ROM word address width, one 32-bit word per 8-pixel group
`define OBJ_ROM_AW 18

`endif

// File: rtl/obj_pkg.sv
//######################################
// Object engine types
// Table entry, draw command, pixel, FSMs
//######################################
`include "obj_macros.svh"

package obj_pkg;

    // One table entry as read by the scanner, word 0 in the low bits
    typedef struct packed {
        // Word 3
        logic [15:0] offset;
        // Word 2
        logic [3:0]  rsv2;
        logic [2:0]  width;     // 8-pixel groups, 0 acts as 1
        logic [1:0]  bank;
        logic [6:0]  pal;
        // Word 1
        logic        last;      // End of table marker
        logic [2:0]  rsv1;
        logic [1:0]  prio;
        logic        hflip;
        logic [8:0]  xpos;
        // Word 0
        logic [6:0]  height;
        logic [8:0]  top;
    } obj_entry_t;

    // Scanner to drawer
    typedef struct packed {
        logic [8:0]             xpos;
        logic                   hflip;
        logic [1:0]             prio;
        logic [6:0]             pal;
        logic [2:0]             width;  // Never 0 here
        logic [`OBJ_ROM_AW-1:0] addr;   // First group of the line
    } draw_cmd_t;

    // Line buffer pixel, colour 0 is transparent
    typedef struct packed {
        logic [1:0] prio;
        logic [6:0] pal;
        logic [3:0] colour;
    } obj_pxl_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_TEST,
        S_ISSUE,
        S_DONE
    } scan_state_e;

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_WRITE
    } draw_state_e;

endpackage

// File: rtl/obj_table_ram.sv
//######################################
// Object table RAM
// Two banks, CPU port and scanner port
//######################################
`timescale 1ns/1ps
`include "obj_macros.svh"

module obj_table_ram (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        obj_swap,
    // CPU side
    input  logic        cpu_cs,
    input  logic [8:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dswn,
    output logic [15:0] cpu_din,
    // Scanner side
    input  logic [8:0]  tbl_addr,
    output logic [15:0] tbl_dout
);

    localparam int BANK_WORDS = `OBJ_ENTRIES * `OBJ_WORDS;

    // Both banks in one array, bank select is the address MSB
    logic [15:0] mem [2*BANK_WORDS];

    // Bank written by the CPU, scanner reads the other one
    logic        cpu_bank;
    logic [9:0]  cpu_idx;
    logic [9:0]  tbl_idx;
    logic        we_lo;
    logic        we_hi;

    assign cpu_idx = {cpu_bank, cpu_addr};
    assign tbl_idx = {~cpu_bank, tbl_addr};

    // Byte enables are active low
    assign we_lo = cpu_cs & ~dswn[0];
    assign we_hi = cpu_cs & ~dswn[1];

    // Swap on the edge after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_bank <= 1'b0;
        end else if (obj_swap) begin
            cpu_bank <= ~cpu_bank;
        end
    end

    // CPU port, byte lanes
    always_ff @(posedge clk) begin
        if (we_lo) begin
            mem[cpu_idx][7:0] <= cpu_dout[7:0];
        end
        if (we_hi) begin
            mem[cpu_idx][15:8] <= cpu_dout[15:8];
        end
        // Read data one cycle after the strobe, old data on a write
        if (cpu_cs) begin
            cpu_din <= mem[cpu_idx];
        end
    end

    // Scanner port, read every cycle
    always_ff @(posedge clk) begin
        tbl_dout <= mem[tbl_idx];
    end

    // Swap must be a single-cycle strobe
    a_swap_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        obj_swap |=> !obj_swap
    );

endmodule

// File: rtl/obj_scan.sv
//######################################
// Object scanner
// Walks the table, issues draw commands
//######################################
`timescale 1ns/1ps
`include "obj_macros.svh"

module obj_scan import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hstart,
    input  logic [8:0]  vrender,
    // Table read port
    output logic [8:0]  tbl_addr,
    input  logic [15:0] tbl_dout,
    // Drawer
    output logic        dr_start,
    output draw_cmd_t   dr_cmd,
    input  logic        dr_busy
);

    localparam int IW = $clog2(`OBJ_ENTRIES);
    localparam int WW = $clog2(`OBJ_WORDS);
    // Word counter value when the last word arrives
    localparam logic [WW:0] LAST_CNT = (WW+1)'(`OBJ_WORDS);
    localparam logic [IW-1:0] LAST_IDX = IW'(`OBJ_ENTRIES - 1);

    scan_state_e   state;
    logic [IW-1:0] idx;
    logic [WW:0]   cnt;
    logic [8:0]    target;
    obj_entry_t    ent;
    logic [8:0]    dy;
    logic          hit;
    logic          last_ent;
    logic [2:0]    width_n;

    // Word address runs one cycle ahead of the data
    assign tbl_addr = {idx, cnt[WW-1:0]};

    // Line inside the sprite, wraps for lines above the top
    assign dy       = target - ent.top;
    assign hit      = dy < {2'b00, ent.height};
    assign last_ent = idx == LAST_IDX;
    assign width_n  = (ent.width == 3'd0) ? 3'd1 : ent.width;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            idx      <= '0;
            cnt      <= '0;
            target   <= '0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            if (hstart) begin
                // New line, render the next one
                state  <= S_READ;
                idx    <= '0;
                cnt    <= '0;
                target <= vrender + 9'd1;
            end else begin
                case (state)
                    S_READ: begin
                        if (cnt == LAST_CNT) begin
                            cnt   <= '0;
                            state <= S_TEST;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    S_TEST: begin
                        if (ent.last) begin
                            state <= S_DONE;
                        end else if (hit) begin
                            state <= S_ISSUE;
                        end else if (last_ent) begin
                            state <= S_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_READ;
                        end
                    end
                    S_ISSUE: begin
                        // Wait for the drawer to go idle
                        if (!dr_busy) begin
                            dr_start <= 1'b1;
                            if (last_ent) begin
                                state <= S_DONE;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= S_READ;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Entry words and command payload
    always_ff @(posedge clk) begin
        if (state == S_READ && cnt != '0) begin
            ent[(cnt - 1'b1) * 16 +: 16] <= tbl_dout;
        end
        if (state == S_TEST) begin
            dr_cmd.xpos  <= ent.xpos;
            dr_cmd.hflip <= ent.hflip;
            dr_cmd.prio  <= ent.prio;
            dr_cmd.pal   <= ent.pal;
            dr_cmd.width <= width_n;
            // One ROM word per group, one row of groups per line
            dr_cmd.addr  <= {ent.bank, ent.offset} + dy[6:0] * width_n;
        end
    end

    // Scanner only starts an idle drawer
    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        dr_start |-> !dr_busy
    );

endmodule

// File: rtl/obj_draw.sv
//######################################
// Object drawer
// ROM fetch and line buffer pixel writes
//######################################
`timescale 1ns/1ps
`include "obj_macros.svh"

module obj_draw import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Scanner
    input  logic                   dr_start,
    input  draw_cmd_t              dr_cmd,
    output logic                   dr_busy,
    // Graphics ROM
    output logic                   obj_cs,
    output logic [`OBJ_ROM_AW-1:0] obj_addr,
    input  logic                   obj_ok,
    input  logic [31:0]            obj_data,
    // Line buffer
    output logic                   buf_we,
    output logic [8:0]             buf_addr,
    output obj_pxl_t               buf_data
);

    draw_state_e state;
    draw_cmd_t   cmd;
    // Group and nibble counters form the screen offset
    logic [2:0]  grp;
    logic [2:0]  nib;
    logic [31:0] sh;
    logic [3:0]  colour;
    logic        last_grp;

    // Normal: MSB nibble first, hflip: LSB nibble first
    assign colour   = cmd.hflip ? sh[3:0] : sh[31:28];
    assign last_grp = grp == cmd.width - 3'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= D_IDLE;
            dr_busy <= 1'b0;
            obj_cs  <= 1'b0;
            buf_we  <= 1'b0;
            grp     <= '0;
            nib     <= '0;
        end else begin
            buf_we <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (dr_start) begin
                        dr_busy <= 1'b1;
                        obj_cs  <= 1'b1;
                        grp     <= '0;
                        state   <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    // Hold the request until the ROM answers
                    if (obj_ok) begin
                        obj_cs <= 1'b0;
                        nib    <= '0;
                        state  <= D_WRITE;
                    end
                end
                D_WRITE: begin
                    // Transparent nibbles leave the buffer alone
                    buf_we <= colour != 4'd0;
                    nib    <= nib + 3'd1;
                    if (nib == 3'd7) begin
                        if (last_grp) begin
                            dr_busy <= 1'b0;
                            state   <= D_IDLE;
                        end else begin
                            grp    <= grp + 3'd1;
                            obj_cs <= 1'b1;
                            state  <= D_FETCH;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: begin
                if (dr_start) begin
                    cmd <= dr_cmd;
                    // Mirrored sprites start from the rightmost group
                    obj_addr <= dr_cmd.hflip ? dr_cmd.addr + dr_cmd.width - 1'b1
                                             : dr_cmd.addr;
                end
            end
            D_FETCH: begin
                if (obj_ok) begin
                    sh <= obj_data;
                end
            end
            D_WRITE: begin
                sh <= cmd.hflip ? sh >> 4 : sh << 4;
                // Wraps at the line end
                buf_addr        <= cmd.xpos + {3'b000, grp, nib};
                buf_data.prio   <= cmd.prio;
                buf_data.pal    <= cmd.pal;
                buf_data.colour <= colour;
                if (nib == 3'd7) begin
                    obj_addr <= cmd.hflip ? obj_addr - 1'b1 : obj_addr + 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ROM request stays put while waiting
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        obj_cs && !obj_ok |=> obj_cs && $stable(obj_addr)
    );

endmodule

// File: rtl/obj_line_buffer.sv
//######################################
// Object line buffer
// Two halves, playback with erase
//######################################
`timescale 1ns/1ps
`include "obj_macros.svh"

module obj_line_buffer import obj_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hstart,
    input  logic       LHBL,
    input  logic       pxl_cen,
    // Drawer writes
    input  logic       buf_we,
    input  logic [8:0] buf_addr,
    input  obj_pxl_t   buf_data,
    // Video out
    output obj_pxl_t   pxl
);

    localparam int AW = $clog2(`OBJ_LINE_W);

    // Half select is the address MSB
    obj_pxl_t      mem [2*`OBJ_LINE_W];
    logic          wr_half;
    logic [AW-1:0] rd_cnt;
    logic          rd_en;
    logic [AW:0]   rd_idx;

    assign rd_en  = LHBL & pxl_cen;
    assign rd_idx = {~wr_half, rd_cnt};

    // Halves swap with the scanner restart
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_half <= 1'b0;
        end else if (hstart) begin
            wr_half <= ~wr_half;
        end
    end

    // Counter parks at 0 during blanking
    always_ff @(posedge clk) begin
        if (!rst_n || !LHBL) begin
            rd_cnt <= '0;
        end else if (pxl_cen) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // Draw port on one half, erase port on the other
    always_ff @(posedge clk) begin
        if (buf_we) begin
            mem[{wr_half, buf_addr}] <= buf_data;
        end
        if (rd_en) begin
            mem[rd_idx] <= '0;
        end
    end

    // Old contents go out as the location clears
    always_ff @(posedge clk) begin
        if (!rst_n || !LHBL) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= mem[rd_idx];
        end
    end

endmodule

// File: rtl/obj_engine.sv
//######################################
// Object engine top level
// Table, scanner, drawer and line buffer
//######################################
`timescale 1ns/1ps
`include "obj_macros.svh"

module obj_engine import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // CPU
    input  logic                   cpu_cs,
    input  logic [8:0]             cpu_addr,
    input  logic [15:0]            cpu_dout,
    input  logic [1:0]             dswn,
    output logic [15:0]            cpu_din,
    input  logic                   obj_swap,
    // Graphics ROM
    output logic                   obj_cs,
    output logic [`OBJ_ROM_AW-1:0] obj_addr,
    input  logic                   obj_ok,
    input  logic [31:0]            obj_data,
    // Video timing
    input  logic                   hstart,
    input  logic                   LHBL,
    input  logic                   pxl_cen,
    input  logic [8:0]             vrender,
    output obj_pxl_t               pxl
);

    // Table scan
    logic [8:0]  tbl_addr;
    logic [15:0] tbl_dout;

    // Draw commands
    logic        dr_start;
    logic        dr_busy;
    draw_cmd_t   dr_cmd;

    // Line buffer writes
    logic        buf_we;
    logic [8:0]  buf_addr;
    obj_pxl_t    buf_data;

    obj_table_ram u_ram (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .obj_swap ( obj_swap ),
        .cpu_cs   ( cpu_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dswn     ( dswn     ),
        .cpu_din  ( cpu_din  ),
        .tbl_addr ( tbl_addr ),
        .tbl_dout ( tbl_dout )
    );

    obj_scan u_scan (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .hstart   ( hstart   ),
        .vrender  ( vrender  ),
        .tbl_addr ( tbl_addr ),
        .tbl_dout ( tbl_dout ),
        .dr_start ( dr_start ),
        .dr_cmd   ( dr_cmd   ),
        .dr_busy  ( dr_busy  )
    );

    obj_draw u_draw (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .dr_start ( dr_start ),
        .dr_cmd   ( dr_cmd   ),
        .dr_busy  ( dr_busy  ),
        .obj_cs   ( obj_cs   ),
        .obj_addr ( obj_addr ),
        .obj_ok   ( obj_ok   ),
        .obj_data ( obj_data ),
        .buf_we   ( buf_we   ),
        .buf_addr ( buf_addr ),
        .buf_data ( buf_data )
    );

    obj_line_buffer u_line (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .hstart   ( hstart   ),
        .LHBL     ( LHBL     ),
        .pxl_cen  ( pxl_cen  ),
        .buf_we   ( buf_we   ),
        .buf_addr ( buf_addr ),
        .buf_data ( buf_data ),
        .pxl      ( pxl      )
    );

endmodule

// File: verif/tb_clkgen.sv
//######################################
// Testbench clock and reset
//######################################
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Reset held low for a few edges
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verif/obj_engine_tb.sv
//######################################
// Object engine testbench
// Table writes, ROM model, line checks
//######################################
`timescale 1ns/1ps
`include "obj_macros.svh"

module obj_engine_tb import obj_pkg::*; ();

    localparam int DRAW_WAIT   = 1200;
    localparam int LINE_CYCLES = DRAW_WAIT + `OBJ_LINE_W + 16;
    localparam int NUM_LINES   = 20;

    logic        clk;
    logic        rst_n;
    logic        cpu_cs;
    logic [8:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dswn;
    logic [15:0] cpu_din;
    logic        obj_swap;
    logic        obj_cs;
    logic [17:0] obj_addr;
    logic        obj_ok;
    logic [31:0] obj_data;
    logic        hstart;
    logic        LHBL;
    logic        pxl_cen;
    logic [8:0]  vrender;
    obj_pxl_t    pxl;

    integer      seed;
    logic [1:0]  wait_cnt;
    // Table model indexed by bank then word
    logic [15:0] bank_mem [2][512];
    bit          cpu_bank;
    obj_pxl_t    prev_ref [`OBJ_LINE_W];
    obj_pxl_t    next_ref [`OBJ_LINE_W];

    tb_clkgen #(.PERIOD(8.0), .RST_CYCLES(3)) u_clk (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    obj_engine u_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cpu_cs   ( cpu_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dswn     ( dswn     ),
        .cpu_din  ( cpu_din  ),
        .obj_swap ( obj_swap ),
        .obj_cs   ( obj_cs   ),
        .obj_addr ( obj_addr ),
        .obj_ok   ( obj_ok   ),
        .obj_data ( obj_data ),
        .hstart   ( hstart   ),
        .LHBL     ( LHBL     ),
        .pxl_cen  ( pxl_cen  ),
        .vrender  ( vrender  ),
        .pxl      ( pxl      )
    );

    // Graphics ROM contents with zero nibbles at fixed spots
    function automatic logic [31:0] rom_word(input logic [17:0] a);
        logic [31:0] h;
        logic [31:0] mask;
        h    = ({14'd0, a} * 32'h9e37_79b1) ^ {a[9:0], a, a[3:0]};
        mask = a[0] ? 32'hf0ff_0ff0 : 32'h0ff0_fff0;
        return h & mask;
    endfunction

    // ROM answers after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            obj_ok   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (obj_ok) begin
            obj_ok <= 1'b0;
        end else if (obj_cs) begin
            if (wait_cnt == 2'd0) begin
                obj_ok   <= 1'b1;
                obj_data <= rom_word(obj_addr);
                wait_cnt <= 2'($random(seed) & 3);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic cpu_write(input logic [8:0] a, input logic [15:0] d, input logic [1:0] be_n);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_addr <= a;
        cpu_dout <= d;
        dswn     <= be_n;
        @(posedge clk);
        cpu_cs   <= 1'b0;
        dswn     <= 2'b11;
        if (!be_n[0]) bank_mem[cpu_bank][a][7:0] = d[7:0];
        if (!be_n[1]) bank_mem[cpu_bank][a][15:8] = d[15:8];
    endtask

    task automatic cpu_check(input logic [8:0] a);
        logic [15:0] exp;
        exp = bank_mem[cpu_bank][a];
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_addr <= a;
        dswn     <= 2'b11;
        @(posedge clk);
        cpu_cs <= 1'b0;
        @(negedge clk);
        assert (cpu_din === exp) else
            fail_now($sformatf("FAILED cpu_din at %h: got %h, expected %h", a, cpu_din, exp));
    endtask

    task automatic swap_banks();
        @(posedge clk);
        obj_swap <= 1'b1;
        @(posedge clk);
        obj_swap <= 1'b0;
        cpu_bank = ~cpu_bank;
    endtask

    // One entry as four words
    task automatic put_obj(input int e, input logic [8:0] top, input logic [6:0] h,
                           input logic [8:0] x, input logic hf, input logic [1:0] pr,
                           input logic [6:0] pal, input logic [1:0] bk,
                           input logic [2:0] wd, input logic [15:0] off);
        cpu_write(9'(e * 4), {h, top}, 2'b00);
        cpu_write(9'(e * 4 + 1), {1'b0, 3'b000, pr, hf, x}, 2'b00);
        cpu_write(9'(e * 4 + 2), {4'b0000, wd, bk, pal}, 2'b00);
        cpu_write(9'(e * 4 + 3), off, 2'b00);
    endtask

    task automatic put_end(input int e);
        cpu_write(9'(e * 4), 16'h0000, 2'b00);
        cpu_write(9'(e * 4 + 1), 16'h8000, 2'b00);
        cpu_write(9'(e * 4 + 2), 16'h0000, 2'b00);
        cpu_write(9'(e * 4 + 3), 16'h0000, 2'b00);
    endtask

    // Expected line from the scanned bank with later entries on top
    task automatic build_ref(input logic [8:0] target);
        logic [15:0] w [4];
        logic [8:0]  dy;
        logic [2:0]  wd;
        logic [17:0] base;
        logic [31:0] word;
        logic [3:0]  col;
        int          pos;
        for (int i = 0; i < `OBJ_LINE_W; i++) next_ref[i] = '0;
        for (int e = 0; e < `OBJ_ENTRIES; e++) begin
            for (int k = 0; k < 4; k++) w[k] = bank_mem[~cpu_bank][e * 4 + k];
            if (w[1][15]) break;
            dy = target - w[0][8:0];
            if (dy < {2'b00, w[0][15:9]}) begin
                wd   = (w[2][11:9] == 3'd0) ? 3'd1 : w[2][11:9];
                base = {w[2][8:7], w[3]} + 18'(dy) * 18'(wd);
                for (int g = 0; g < wd; g++) begin
                    // Mirrored sprites read groups right to left
                    word = rom_word(w[1][9] ? base + 18'(wd - 1 - g) : base + 18'(g));
                    for (int n = 0; n < 8; n++) begin
                        col = w[1][9] ? word[4 * n +: 4] : word[28 - 4 * n +: 4];
                        pos = (w[1][8:0] + 8 * g + n) % `OBJ_LINE_W;
                        if (col != 4'd0) next_ref[pos] = {w[1][11:10], w[2][6:0], col};
                    end
                end
            end
        end
    endtask

    // Start a line and play back the one drawn before it
    task automatic run_line(input logic [8:0] v, input bit check);
        build_ref(v + 9'd1);
        @(posedge clk);
        hstart  <= 1'b1;
        vrender <= v;
        @(posedge clk);
        hstart <= 1'b0;
        repeat (DRAW_WAIT) @(posedge clk);
        LHBL    <= 1'b1;
        pxl_cen <= 1'b1;
        for (int i = 0; i < `OBJ_LINE_W; i++) begin
            @(posedge clk);
            if (i == `OBJ_LINE_W - 1) begin
                LHBL    <= 1'b0;
                pxl_cen <= 1'b0;
            end
            @(negedge clk);
            if (check) begin
                assert (pxl === prev_ref[i]) else
                    fail_now($sformatf("FAILED pxl at x %0d (line %0d): got %h, expected %h",
                                       i, v, pxl, prev_ref[i]));
            end
        end
        for (int i = 0; i < `OBJ_LINE_W; i++) prev_ref[i] = next_ref[i];
    endtask

    task automatic cpu_byte_lanes();
        cpu_write(9'h1f0, 16'ha55a, 2'b00);
        cpu_check(9'h1f0);
        cpu_write(9'h1f0, 16'h1234, 2'b10);
        cpu_check(9'h1f0);
        cpu_write(9'h1f0, 16'hbeef, 2'b01);
        cpu_check(9'h1f0);
        cpu_write(9'h1f0, 16'hffff, 2'b11);
        cpu_check(9'h1f0);
    endtask

    task automatic single_sprite();
        put_obj(0, 9'd20, 7'd4, 9'd100, 1'b0, 2'd2, 7'd5, 2'd1, 3'd3, 16'h0123);
        put_end(1);
        // Past the end marker so never shown
        put_obj(2, 9'd20, 7'd4, 9'd300, 1'b0, 2'd1, 7'd9, 2'd0, 3'd2, 16'h0400);
        swap_banks();
        for (int v = 18; v <= 23; v++) run_line(9'(v), 1'b1);
    endtask

    task automatic bank_swap();
        put_obj(0, 9'd20, 7'd2, 9'd300, 1'b0, 2'd3, 7'd33, 2'd2, 3'd0, 16'h1000);
        put_end(1);
        // Old bank still scanned before the swap
        run_line(9'd19, 1'b1);
        swap_banks();
        run_line(9'd19, 1'b1);
        run_line(9'd20, 1'b1);
    endtask

    task automatic overlap_order();
        put_obj(0, 9'd40, 7'd8, 9'd200, 1'b0, 2'd0, 7'd1, 2'd0, 3'd2, 16'h2000);
        put_obj(1, 9'd40, 7'd8, 9'd204, 1'b0, 2'd1, 7'd2, 2'd0, 3'd2, 16'h2101);
        put_end(2);
        swap_banks();
        for (int v = 40; v <= 42; v++) run_line(9'(v), 1'b1);
    endtask

    task automatic flip_and_wrap();
        put_obj(0, 9'd60, 7'd3, 9'd40, 1'b1, 2'd2, 7'd7, 2'd1, 3'd3, 16'h3003);
        put_obj(1, 9'd60, 7'd3, 9'd500, 1'b0, 2'd1, 7'd8, 2'd3, 3'd3, 16'h0777);
        put_end(2);
        swap_banks();
        for (int v = 59; v <= 61; v++) run_line(9'(v), 1'b1);
    endtask

    task automatic erase_after_read();
        put_end(0);
        swap_banks();
        // Previous full line plays out before the empty ones
        run_line(9'd61, 1'b1);
        run_line(9'd62, 1'b1);
        run_line(9'd63, 1'b1);
    endtask

    // Watchdog sized from the line count
    initial begin
        #((NUM_LINES * LINE_CYCLES + 4000) * 8);
        $display("Timeout: the tests did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        seed     = 32'h01c1_450b;
        cpu_cs   = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dswn     = 2'b11;
        obj_swap = 1'b0;
        obj_ok   = 1'b0;
        obj_data = '0;
        hstart   = 1'b0;
        LHBL     = 1'b0;
        pxl_cen  = 1'b0;
        vrender  = '0;
        cpu_bank = 1'b0;
        for (int i = 0; i < `OBJ_LINE_W; i++) prev_ref[i] = '0;
        wait (rst_n);
        @(posedge clk);
        // Empty table in bank 0 and two lines to flush both halves
        put_end(0);
        swap_banks();
        run_line(9'd0, 1'b0);
        run_line(9'd0, 1'b0);
        cpu_byte_lanes();
        single_sprite();
        bank_swap();
        overlap_order();
        flip_and_wrap();
        erase_after_read();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/obj_pkg.sv
rtl/obj_table_ram.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_line_buffer.sv
rtl/obj_engine.sv
verif/tb_clkgen.sv
verif/obj_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= obj_engine_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
